// ==== Bender.yml ====
package:
  name: mem_stage

sources:
  # package first, then the stage parts, then the top
  - verilog/lsu_pkg.sv
  - verilog/lsu_req_decode.sv
  - verilog/lsu_axi_master.sv
  - verilog/lsu_load_align.sv
  - verilog/dmem_axil.sv
  - verilog/mem_stage.sv
  - target: simulation
    files:
      - tb/mem_stage_checker.sv
      - tb/tb_mem_stage.sv

// ==== build.f ====
verilog/lsu_pkg.sv
verilog/lsu_req_decode.sv
verilog/lsu_axi_master.sv
verilog/lsu_load_align.sv
verilog/dmem_axil.sv
verilog/mem_stage.sv
tb/mem_stage_checker.sv
tb/tb_mem_stage.sv

// ==== tb/mem_stage_checker.sv ====
// mem stage protocol checker
`timescale 1ns/1ps
`default_nettype none

module mem_stage_checker (
    input logic clk,
    input logic rst,
    input logic valid_i,
    input logic busy_i,
    input logic wb_valid_i,
    input logic ar_valid_i,
    input logic ar_ready_i,
    input logic aw_valid_i,
    input logic aw_ready_i,
    input logic w_valid_i,
    input logic w_ready_i,
    input logic r_valid_i,
    input logic r_ready_i,
    input logic b_valid_i,
    input logic b_ready_i
);

    // everything quiet right after reset
    reset_quiet: assert property (@(posedge clk)
        rst |=> !busy_i && !wb_valid_i && !ar_valid_i && !aw_valid_i && !w_valid_i
            && !r_valid_i && !b_valid_i && !ar_ready_i && !aw_ready_i && !w_ready_i)
        else $error("stage or bus signal high right after reset");

    // master side valids held until accepted
    ar_hold: assert property (@(posedge clk) disable iff (rst)
        ar_valid_i && !ar_ready_i |=> ar_valid_i)
        else $error("read address valid dropped before ready");
    aw_hold: assert property (@(posedge clk) disable iff (rst)
        aw_valid_i && !aw_ready_i |=> aw_valid_i)
        else $error("write address valid dropped before ready");
    w_hold: assert property (@(posedge clk) disable iff (rst)
        w_valid_i && !w_ready_i |=> w_valid_i)
        else $error("write data valid dropped before ready");

    // slave responses held the same way
    r_hold: assert property (@(posedge clk) disable iff (rst)
        r_valid_i && !r_ready_i |=> r_valid_i)
        else $error("read data valid dropped before ready");
    b_hold: assert property (@(posedge clk) disable iff (rst)
        b_valid_i && !b_ready_i |=> b_valid_i)
        else $error("write response valid dropped before ready");

    // writeback is a single-cycle pulse
    wb_pulse: assert property (@(posedge clk) disable iff (rst)
        wb_valid_i |=> !wb_valid_i)
        else $error("writeback valid held longer than one cycle");

    // one instruction in flight at most
    no_strobe_busy: assert property (@(posedge clk) disable iff (rst)
        busy_i |-> !valid_i)
        else $error("instruction strobe arrived while the stage was busy");

endmodule

bind mem_stage mem_stage_checker i_checker (
    .clk        (clk),
    .rst        (rst),
    .valid_i    (valid_i),
    .busy_i     (busy_o),
    .wb_valid_i (wb_valid_o),
    .ar_valid_i (ar_valid),
    .ar_ready_i (ar_ready),
    .aw_valid_i (aw_valid),
    .aw_ready_i (aw_ready),
    .w_valid_i  (w_valid),
    .w_ready_i  (w_ready),
    .r_valid_i  (r_valid),
    .r_ready_i  (r_ready),
    .b_valid_i  (b_valid),
    .b_ready_i  (b_ready)
);

`default_nettype wire

// ==== tb/mem_trace.txt ====
// name alu_result wdata load store wreg wd check exp_wd exp_wreg exp_wdata exp_err max_gap
// names 0 alu_pass 1 store_load 2 byte_store 3 half_store 4 load_extend 5 bad_address 6 memory_kept
1b
0 12345678 00000000 0 0 05 1 1 1 05 12345678 0 0
0 fffffff0 00000000 0 0 0a 1 1 1 0a fffffff0 0 3
1 00000010 cafef00d 0 3 00 0 1 0 00 00000010 0 1
1 00000010 00000000 3 0 03 1 1 1 03 cafef00d 0 2
1 00000020 11223344 0 3 00 0 1 0 00 00000020 0 0
2 00000021 123456aa 0 1 00 0 1 0 00 00000021 0 3
2 00000020 00000000 3 0 04 1 1 1 04 1122aa44 0 0
2 00000023 00000077 0 1 00 0 1 0 00 00000023 0 1
2 00000020 000000e1 0 1 00 0 1 0 00 00000020 0 0
2 00000022 00000099 0 1 00 0 1 0 00 00000022 0 2
2 00000020 00000000 3 0 04 1 1 1 04 7799aae1 0 0
3 00000022 abcd8765 0 2 00 0 1 0 00 00000022 0 1
3 00000020 0000f00f 0 2 00 0 1 0 00 00000020 0 0
3 00000020 00000000 3 0 07 1 1 1 07 8765f00f 0 3
4 00000021 00000000 1 0 08 1 1 1 08 fffffff0 0 0
4 00000021 00000000 4 0 08 1 1 1 08 000000f0 0 1
4 00000020 00000000 1 0 09 1 1 1 09 0000000f 0 0
4 00000023 00000000 4 0 09 1 1 1 09 00000087 0 2
4 00000022 00000000 2 0 0b 1 1 1 0b ffff8765 0 0
4 00000022 00000000 5 0 0b 1 1 1 0b 00008765 0 1
4 00000020 00000000 2 0 0c 1 1 1 0c fffff00f 0 0
5 00000110 deadbeef 0 3 00 0 1 0 00 00000110 1 2
5 00000121 00000055 0 1 00 0 1 0 00 00000121 1 0
5 00000404 00000000 3 0 06 1 0 0 06 00000000 1 1
6 00000010 00000000 3 0 0d 1 1 1 0d cafef00d 0 0
6 00000020 00000000 3 0 0e 1 1 1 0e 8765f00f 0 3
0 00000abc 00000000 0 0 1f 1 1 1 1f 00000abc 0 0

// ==== tb/tb_mem_stage.sv ====
// memory stage trace testbench
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;
    import lsu_pkg::*;

    localparam int FIELDS  = 13;
    localparam int MAX_OPS = 64;
    localparam int TIMEOUT = 200;

    logic        clk;
    logic        rst;
    logic        valid_i;
    lsu_op_t     op_i;
    logic        busy_o;
    logic        wb_valid_o;
    wb_t         wb_o;

    // record count in word 0 then FIELDS words per record
    logic [31:0] trace_mem [0:FIELDS*MAX_OPS];
    integer      seed;
    int          num_ops;
    int          passed;
    int          failed;
    logic        hung;
    int          wb_pulses;

    mem_stage #(
        .MEM_WORDS_LOG2 (6),
        .RESP_DELAY     (2)
    ) i_dut (
        .clk        (clk),
        .rst        (rst),
        .valid_i    (valid_i),
        .op_i       (op_i),
        .busy_o     (busy_o),
        .wb_valid_o (wb_valid_o),
        .wb_o       (wb_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // running count of writeback pulses
    always @(posedge clk) begin
        if (wb_valid_o) begin
            wb_pulses <= wb_pulses + 1;
        end
    end

    function automatic string name_of(input logic [31:0] idx);
        case (idx)
            0: return "alu_pass";
            1: return "store_load";
            2: return "byte_store";
            3: return "half_store";
            4: return "load_extend";
            5: return "bad_address";
            6: return "memory_kept";
            default: return "unnamed";
        endcase
    endfunction

    task automatic show_mismatch(input string name, input wb_t exp, input wb_t act);
        string exp_s;
        string act_s;

        exp_s = $sformatf("wd=%0b wreg=%0d wdata=%h err=%0b",
                          exp.wd, exp.wreg, exp.wdata, exp.err);
        act_s = $sformatf("wd=%0b wreg=%0d wdata=%h err=%0b",
                          act.wd, act.wreg, act.wdata, act.err);
        $display("Error: %s expected %s actual %s", name, exp_s, act_s);
    endtask

    // runs one trace record through the stage
    task automatic run_op(input int n);
        int      base;
        lsu_op_t op;
        wb_t     exp;
        logic    full_check;
        logic    is_mem;
        logic    seen;
        logic    ok;
        int      gap;
        int      cycles;
        int      pulses_before;
        string   name;

        base          = 1 + n * FIELDS;
        name          = name_of(trace_mem[base]);
        op.alu_result = trace_mem[base + 1];
        op.wdata      = trace_mem[base + 2];
        op.load_type  = load_type_e'(trace_mem[base + 3][2:0]);
        op.store_type = store_type_e'(trace_mem[base + 4][1:0]);
        op.wreg       = trace_mem[base + 5][4:0];
        op.wd         = trace_mem[base + 6][0];
        full_check    = trace_mem[base + 7][0];
        exp.wd        = trace_mem[base + 8][0];
        exp.wreg      = trace_mem[base + 9][4:0];
        exp.wdata     = trace_mem[base + 10];
        exp.err       = trace_mem[base + 11][0];
        // last column is the largest idle gap
        gap           = $unsigned($random(seed)) % (trace_mem[base + 12] + 1);
        is_mem        = (op.load_type != ld_none) || (op.store_type != st_none);
        ok            = 1'b1;
        seen          = 1'b0;
        cycles        = 0;
        pulses_before = wb_pulses;

        repeat (gap) @(posedge clk);
        @(posedge clk);
        valid_i <= 1'b1;
        op_i    <= op;
        @(posedge clk);
        valid_i <= 1'b0;

        // count from the edge that took the strobe
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            seen = wb_valid_o;
        end

        if (!seen) begin
            $display("test %0d (%s): no writeback within %0d cycles", n, name, TIMEOUT);
            hung = 1'b1;
            failed++;
        end else begin
            assert (!busy_o) else begin
                $display("test %0d (%s): busy still high alongside writeback", n, name);
                ok = 1'b0;
            end
            // capture then issue only
            if (!is_mem) begin
                assert (cycles == 2) else begin
                    $display("Error: %s latency expected 2 actual %0d", name, cycles);
                    ok = 1'b0;
                end
            end
            if (full_check) begin
                assert (wb_o === exp) else begin
                    show_mismatch(name, exp, wb_o);
                    ok = 1'b0;
                end
            end else begin
                // data on a bus error is not defined
                assert (wb_o.wd === exp.wd && wb_o.wreg === exp.wreg && wb_o.err === exp.err)
                else begin
                    show_mismatch(name, exp, wb_o);
                    ok = 1'b0;
                end
            end
            @(negedge clk);
            assert (!wb_valid_o) else begin
                $display("test %0d (%s): writeback valid lasted more than one cycle", n, name);
                ok = 1'b0;
            end
            // exactly one pulse since the previous record ended
            assert (wb_pulses == pulses_before + 1) else begin
                $display("test %0d (%s): %0d writeback pulses seen instead of one",
                         n, name, wb_pulses - pulses_before);
                ok = 1'b0;
            end
            if (ok) begin
                passed++;
            end else begin
                failed++;
            end
            $display("test %0d (%s): %s", n, name, ok ? "pass" : "fail");
        end
    endtask

    initial begin
        seed    = 94528;
        passed  = 0;
        failed  = 0;
        hung    = 1'b0;
        rst     = 1'b1;
        valid_i = 1'b0;
        op_i    = '0;
        $readmemh("tb/mem_trace.txt", trace_mem);
        num_ops = trace_mem[0];

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (!busy_o && !wb_valid_o) else begin
            $display("reset: busy or writeback valid still high after reset");
            failed++;
        end

        if (num_ops < 1 || num_ops > MAX_OPS) begin
            $display("trace file holds no usable record count");
            failed++;
        end else begin
            for (int n = 0; n < num_ops && !hung; n++) begin
                run_op(n);
            end
        end

        $display("tests passed %0d, failed %0d", passed, failed);
        if (failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/dmem_axil.sv ====
// axi-lite data scratchpad
`timescale 1ns/1ps
`default_nettype none

module dmem_axil #(
    parameter int MEM_WORDS_LOG2 = 6,
    parameter int RESP_DELAY     = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] ar_addr_i,
    input  logic        ar_valid_i,
    output logic        ar_ready_o,
    output logic [31:0] r_data_o,
    output logic [1:0]  r_resp_o,
    output logic        r_valid_o,
    input  logic        r_ready_i,
    input  logic [31:0] aw_addr_i,
    input  logic        aw_valid_i,
    output logic        aw_ready_o,
    input  logic [31:0] w_data_i,
    input  logic [3:0]  w_strb_i,
    input  logic        w_valid_i,
    output logic        w_ready_o,
    output logic [1:0]  b_resp_o,
    output logic        b_valid_o,
    input  logic        b_ready_i
);
    import lsu_pkg::*;

    localparam int DEPTH = 1 << MEM_WORDS_LOG2;
    localparam int CNT_W = $clog2(RESP_DELAY + 2);

    typedef enum logic [1:0] {
        s_idle,
        s_delay,
        s_resp
    } state_e;

    logic [31:0]               mem [DEPTH];
    state_e                    state_q;
    logic                      rdy_q;
    logic                      is_rd_q;
    logic [CNT_W-1:0]          cnt_q;
    logic [31:0]               rdata_q;
    axi_resp_e                 resp_q;
    logic                      rd_acc;
    logic                      wr_acc;
    logic                      rd_in_range;
    logic                      wr_in_range;
    logic [MEM_WORDS_LOG2-1:0] rd_idx;
    logic [MEM_WORDS_LOG2-1:0] wr_idx;

    // read wins if both arrive together
    assign rd_acc = rdy_q & ar_valid_i;
    assign wr_acc = rdy_q & aw_valid_i & w_valid_i & ~ar_valid_i;

    // write needs address and data in the same cycle
    assign ar_ready_o = rdy_q;
    assign aw_ready_o = rdy_q & w_valid_i & ~ar_valid_i;
    assign w_ready_o  = rdy_q & aw_valid_i & ~ar_valid_i;

    assign rd_in_range = (ar_addr_i[31:MEM_WORDS_LOG2+2] == '0);
    assign wr_in_range = (aw_addr_i[31:MEM_WORDS_LOG2+2] == '0);
    assign rd_idx      = ar_addr_i[MEM_WORDS_LOG2+1:2];
    assign wr_idx      = aw_addr_i[MEM_WORDS_LOG2+1:2];

    // response held until its ready
    assign r_valid_o = (state_q == s_resp) & is_rd_q;
    assign b_valid_o = (state_q == s_resp) & ~is_rd_q;
    assign r_data_o  = rdata_q;
    assign r_resp_o  = resp_q;
    assign b_resp_o  = resp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= s_idle;
            rdy_q   <= 1'b0;
            is_rd_q <= 1'b0;
            cnt_q   <= '0;
        end else begin
            // ready rises one cycle into idle
            rdy_q <= (state_q == s_idle) & ~rd_acc & ~wr_acc;
            case (state_q)
                s_idle: begin
                    if (rd_acc || wr_acc) begin
                        state_q <= s_delay;
                        is_rd_q <= rd_acc;
                        cnt_q   <= CNT_W'(1);
                    end
                end
                s_delay: begin
                    if (cnt_q >= CNT_W'(RESP_DELAY)) begin
                        state_q <= s_resp;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                s_resp: begin
                    if ((r_valid_o && r_ready_i) || (b_valid_o && b_ready_i)) begin
                        state_q <= s_idle;
                    end
                end
                default: begin
                    state_q <= s_idle;
                end
            endcase
        end
    end

    // array access at accept, result parked for the delay
    always_ff @(posedge clk) begin
        if (rd_acc) begin
            rdata_q <= rd_in_range ? mem[rd_idx] : 32'd0;
            resp_q  <= rd_in_range ? resp_okay : resp_slverr;
        end
        if (wr_acc) begin
            resp_q <= wr_in_range ? resp_okay : resp_slverr;
            // strobed lanes only, nothing written out of range
            for (int i = 0; i < 4; i++) begin
                if (wr_in_range && w_strb_i[i]) begin
                    mem[wr_idx][8*i +: 8] <= w_data_i[8*i +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lsu_axi_master.sv ====
// lsu axi-lite access fsm
`timescale 1ns/1ps
`default_nettype none

module lsu_axi_master (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_i,
    input  lsu_pkg::mem_req_t req_i,
    output logic              done_o,
    output logic [31:0]       rdata_o,
    output logic              err_o,
    // read address / read data
    output logic [31:0]       ar_addr_o,
    output logic              ar_valid_o,
    input  logic              ar_ready_i,
    input  logic [31:0]       r_data_i,
    input  logic [1:0]        r_resp_i,
    input  logic              r_valid_i,
    output logic              r_ready_o,
    // write address / write data / write response
    output logic [31:0]       aw_addr_o,
    output logic              aw_valid_o,
    input  logic              aw_ready_i,
    output logic [31:0]       w_data_o,
    output logic [3:0]        w_strb_o,
    output logic              w_valid_o,
    input  logic              w_ready_i,
    input  logic [1:0]        b_resp_i,
    input  logic              b_valid_i,
    output logic              b_ready_o
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        s_idle,
        s_issue,
        s_wait_resp,
        s_finish
    } state_e;

    state_e      state_q;
    state_e      state_d;
    logic        aw_done_q;
    logic        w_done_q;
    logic        acc_q;
    logic        err_q;
    logic [31:0] rdata_q;
    logic        access;
    logic        ar_hs;
    logic        aw_hs;
    logic        w_hs;
    logic        r_hs;
    logic        b_hs;
    logic        aw_ok;
    logic        w_ok;

    assign access = req_i.is_load | req_i.is_store;

    // valids held through issue, never gated by ready
    assign ar_addr_o  = req_i.addr;
    assign ar_valid_o = (state_q == s_issue) & req_i.is_load;
    assign aw_addr_o  = req_i.addr;
    assign aw_valid_o = (state_q == s_issue) & req_i.is_store & ~aw_done_q;
    assign w_data_o   = req_i.wdata;
    assign w_strb_o   = req_i.strb;
    assign w_valid_o  = (state_q == s_issue) & req_i.is_store & ~w_done_q;
    assign r_ready_o  = (state_q == s_wait_resp);
    assign b_ready_o  = (state_q == s_wait_resp);

    assign ar_hs = ar_valid_o & ar_ready_i;
    assign aw_hs = aw_valid_o & aw_ready_i;
    assign w_hs  = w_valid_o & w_ready_i;
    assign r_hs  = r_valid_i & r_ready_o;
    assign b_hs  = b_valid_i & b_ready_o;

    // aw and w may complete in different cycles
    assign aw_ok = aw_done_q | aw_hs;
    assign w_ok  = w_done_q | w_hs;

    // no bus access -> done right in issue
    assign done_o  = ((state_q == s_issue) & ~access) | ((state_q == s_finish) & acc_q);
    assign rdata_o = rdata_q;
    assign err_o   = err_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            s_idle: begin
                if (start_i) begin
                    state_d = s_issue;
                end
            end
            s_issue: begin
                if (!access) begin
                    state_d = s_finish;
                end else if (req_i.is_load) begin
                    if (ar_hs) begin
                        state_d = s_wait_resp;
                    end
                end else if (aw_ok && w_ok) begin
                    state_d = s_wait_resp;
                end
            end
            s_wait_resp: begin
                if (r_hs || b_hs) begin
                    state_d = s_finish;
                end
            end
            s_finish: begin
                // next op may already be starting
                state_d = start_i ? s_issue : s_idle;
            end
            default: begin
                state_d = s_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= s_idle;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            acc_q     <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == s_issue) begin
                acc_q     <= access;
                aw_done_q <= (state_d == s_issue) & aw_ok;
                w_done_q  <= (state_d == s_issue) & w_ok;
            end
            // fresh op starts clean
            if (state_d == s_issue && state_q != s_issue) begin
                err_q <= 1'b0;
            end
            if (r_hs) begin
                err_q <= (r_resp_i != resp_okay);
            end
            if (b_hs) begin
                err_q <= (b_resp_i != resp_okay);
            end
        end
    end

    // load data, presented in finish
    always_ff @(posedge clk) begin
        if (r_hs) begin
            rdata_q <= r_data_i;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/lsu_load_align.sv ====
// load align and writeback
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
    input  logic             clk,
    input  logic             rst,
    input  logic             done_i,
    input  logic [31:0]      rdata_i,
    input  logic             err_i,
    input  lsu_pkg::lsu_op_t op_i,
    input  logic [1:0]       offset_i,
    output logic             wb_valid_o,
    output lsu_pkg::wb_t     wb_o
);
    import lsu_pkg::*;

    mem_word_u   word;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic [31:0] load_val;
    wb_t         wb_d;
    wb_t         wb_q;
    logic        wb_valid_q;

    always_comb begin
        word.word = rdata_i;
    end

    // lane pick by address offset
    assign byte_sel = word.bytes[offset_i];
    assign half_sel = word.halves[offset_i[1]];

    always_comb begin
        case (op_i.load_type)
            ld_lb:   load_val = {{24{byte_sel[7]}}, byte_sel};
            ld_lbu:  load_val = {24'd0, byte_sel};
            ld_lh:   load_val = {{16{half_sel[15]}}, half_sel};
            ld_lhu:  load_val = {16'd0, half_sel};
            ld_lw:   load_val = word.word;
            default: load_val = 32'd0;
        endcase
    end

    always_comb begin
        wb_d.wreg  = op_i.wreg;
        wb_d.err   = err_i;
        // bus error drops the register write
        wb_d.wd    = op_i.wd & ~err_i;
        wb_d.wdata = (op_i.load_type != ld_none) ? load_val : op_i.alu_result;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid_q <= 1'b0;
        end else begin
            wb_valid_q <= done_i;
        end
    end

    always_ff @(posedge clk) begin
        if (done_i) begin
            wb_q <= wb_d;
        end
    end

    assign wb_valid_o = wb_valid_q;
    assign wb_o       = wb_q;

endmodule

`default_nettype wire

// ==== verilog/lsu_pkg.sv ====
// lsu shared types
`default_nettype none

package lsu_pkg;

    // load encoding, unsigned loads appended after lw
    typedef enum logic [2:0] {
        ld_none = 3'd0,
        ld_lb   = 3'd1,
        ld_lh   = 3'd2,
        ld_lw   = 3'd3,
        ld_lbu  = 3'd4,
        ld_lhu  = 3'd5
    } load_type_e;

    typedef enum logic [1:0] {
        st_none = 2'd0,
        st_sb   = 2'd1,
        st_sh   = 2'd2,
        st_sw   = 2'd3
    } store_type_e;

    // axi-lite response codes in use
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_slverr = 2'b10
    } axi_resp_e;

    // executed instruction as handed over by the core
    typedef struct packed {
        logic [31:0] alu_result;
        logic [31:0] wdata;
        load_type_e  load_type;
        store_type_e store_type;
        logic [4:0]  wreg;
        logic        wd;
    } lsu_op_t;

    // word-aligned bus request, store data already in lane position
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  strb;
        logic        is_load;
        logic        is_store;
        logic [1:0]  offset;
        load_type_e  load_type;
    } mem_req_t;

    // one read word, split into byte or halfword lanes
    typedef union packed {
        logic [3:0][7:0]  bytes;
        logic [1:0][15:0] halves;
        logic [31:0]      word;
    } mem_word_u;

    // register writeback record
    typedef struct packed {
        logic        wd;
        logic [4:0]  wreg;
        logic [31:0] wdata;
        logic        err;
    } wb_t;

endpackage

`default_nettype wire

// ==== verilog/lsu_req_decode.sv ====
// lsu request decode
`timescale 1ns/1ps
`default_nettype none

module lsu_req_decode (
    input  logic              clk,
    input  logic              rst,
    input  logic              valid_i,
    input  lsu_pkg::lsu_op_t  op_i,
    input  logic              done_i,
    output logic              busy_o,
    output logic              start_o,
    output lsu_pkg::mem_req_t req_o,
    output lsu_pkg::lsu_op_t  op_o
);
    import lsu_pkg::*;

    lsu_op_t    op_q;
    logic       busy_q;
    logic       accept;
    logic [1:0] offset;

    // strobe only taken while idle
    assign accept  = valid_i & ~busy_q;
    assign start_o = accept;
    assign busy_o  = busy_q;
    assign op_o    = op_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
        end else if (done_i) begin
            busy_q <= 1'b0;
        end else if (accept) begin
            busy_q <= 1'b1;
        end
    end

    // captured instruction, held until the access ends
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= op_i;
        end
    end

    assign offset = op_q.alu_result[1:0];

    always_comb begin
        req_o.addr      = {op_q.alu_result[31:2], 2'b00};
        req_o.offset    = offset;
        req_o.load_type = op_q.load_type;
        req_o.is_load   = (op_q.load_type != ld_none);
        req_o.is_store  = (op_q.store_type != st_none);
        // lane select plus data replicated across lanes
        case (op_q.store_type)
            st_sb: begin
                req_o.strb  = 4'b0001 << offset;
                req_o.wdata = {4{op_q.wdata[7:0]}};
            end
            st_sh: begin
                // halfword lands on lane pair 0-1 or 2-3
                req_o.strb  = 4'b0011 << {offset[1], 1'b0};
                req_o.wdata = {2{op_q.wdata[15:0]}};
            end
            st_sw: begin
                req_o.strb  = 4'b1111;
                req_o.wdata = op_q.wdata;
            end
            default: begin
                req_o.strb  = 4'b0000;
                req_o.wdata = op_q.wdata;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/mem_stage.sv ====
// memory stage top
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
    parameter int MEM_WORDS_LOG2 = 6,
    parameter int RESP_DELAY     = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             valid_i,
    input  lsu_pkg::lsu_op_t op_i,
    output logic             busy_o,
    output logic             wb_valid_o,
    output lsu_pkg::wb_t     wb_o
);
    import lsu_pkg::*;

    // decode <-> master <-> align
    logic        start;
    mem_req_t    req;
    lsu_op_t     op_q;
    logic        done;
    logic [31:0] rdata;
    logic        err;

    // axi-lite link to the scratchpad
    logic [31:0] ar_addr;
    logic        ar_valid;
    logic        ar_ready;
    logic [31:0] r_data;
    logic [1:0]  r_resp;
    logic        r_valid;
    logic        r_ready;
    logic [31:0] aw_addr;
    logic        aw_valid;
    logic        aw_ready;
    logic [31:0] w_data;
    logic [3:0]  w_strb;
    logic        w_valid;
    logic        w_ready;
    logic [1:0]  b_resp;
    logic        b_valid;
    logic        b_ready;

    lsu_req_decode i_decode (
        .clk     (clk),
        .rst     (rst),
        .valid_i (valid_i),
        .op_i    (op_i),
        .done_i  (done),
        .busy_o  (busy_o),
        .start_o (start),
        .req_o   (req),
        .op_o    (op_q)
    );

    lsu_axi_master i_master (
        .clk        (clk),
        .rst        (rst),
        .start_i    (start),
        .req_i      (req),
        .done_o     (done),
        .rdata_o    (rdata),
        .err_o      (err),
        .ar_addr_o  (ar_addr),
        .ar_valid_o (ar_valid),
        .ar_ready_i (ar_ready),
        .r_data_i   (r_data),
        .r_resp_i   (r_resp),
        .r_valid_i  (r_valid),
        .r_ready_o  (r_ready),
        .aw_addr_o  (aw_addr),
        .aw_valid_o (aw_valid),
        .aw_ready_i (aw_ready),
        .w_data_o   (w_data),
        .w_strb_o   (w_strb),
        .w_valid_o  (w_valid),
        .w_ready_i  (w_ready),
        .b_resp_i   (b_resp),
        .b_valid_i  (b_valid),
        .b_ready_o  (b_ready)
    );

    lsu_load_align i_align (
        .clk        (clk),
        .rst        (rst),
        .done_i     (done),
        .rdata_i    (rdata),
        .err_i      (err),
        .op_i       (op_q),
        .offset_i   (req.offset),
        .wb_valid_o (wb_valid_o),
        .wb_o       (wb_o)
    );

    dmem_axil #(
        .MEM_WORDS_LOG2 (MEM_WORDS_LOG2),
        .RESP_DELAY     (RESP_DELAY)
    ) i_dmem (
        .clk        (clk),
        .rst        (rst),
        .ar_addr_i  (ar_addr),
        .ar_valid_i (ar_valid),
        .ar_ready_o (ar_ready),
        .r_data_o   (r_data),
        .r_resp_o   (r_resp),
        .r_valid_o  (r_valid),
        .r_ready_i  (r_ready),
        .aw_addr_i  (aw_addr),
        .aw_valid_i (aw_valid),
        .aw_ready_o (aw_ready),
        .w_data_i   (w_data),
        .w_strb_i   (w_strb),
        .w_valid_i  (w_valid),
        .w_ready_o  (w_ready),
        .b_resp_o   (b_resp),
        .b_valid_o  (b_valid),
        .b_ready_i  (b_ready)
    );

endmodule

`default_nettype wire
